//--- verilog/graphicsPkg.sv
// Graphics package: screen geometry, colours, meter thresholds and stream byte decoding
`default_nettype none

package graphicsPkg;

  // ------------------------------
  // Screen geometry
  // ------------------------------
  localparam int screenCols = 80;
  localparam int screenRows = 30;
  localparam int cellAddrWidth = 12;
  // Glyph in bits 19:12, RGB foreground in bits 11:0
  localparam int cellDataWidth = 20;
  localparam int slotCount = 6;

  // ------------------------------
  // Colours and glyphs
  // ------------------------------
  localparam logic [11:0] colourIdle = 12'h00F;
  localparam logic [11:0] colourSelected = 12'h0E0;
  localparam logic [11:0] colourPlaying = 12'hF00;
  localparam logic [7:0] glyphBlock = 8'hDB;

  // ------------------------------
  // Level meter
  // ------------------------------
  localparam int meterColumn = 78;
  localparam int meterBottomRow = 24;
  localparam int meterRows = 20;

  // Roughly 2 dB apart, entry 0 is the bottom row
  localparam logic [meterRows-1:0][15:0] levelThresholds = {
    16'd26029, 16'd20675, 16'd16423, 16'd13045, 16'd10362,
    16'd8231, 16'd6538, 16'd5193, 16'd4125, 16'd3277,
    16'd2603, 16'd2068, 16'd1642, 16'd1305, 16'd1036,
    16'd823, 16'd654, 16'd519, 16'd413, 16'd328
  };

  // A stream byte is a slot number at message start and a character afterwards
  typedef union packed {
    logic [7:0] glyph;
    struct packed {
      logic [4:0] high;
      logic [2:0] slot;
    } slotSelect;
  } streamByte_u;

  // Linear cell address of a screen position
  function automatic logic [cellAddrWidth-1:0] cellAddr(input logic [4:0] row,
                                                        input logic [6:0] col);
    return cellAddrWidth'(row * screenCols + col);
  endfunction

endpackage

`default_nettype wire

//--- verilog/soundFrontEnd.sv
// Sound front end: sound clock edge strobes, stream byte capture, sample magnitude, frame tick
`default_nettype none

module soundFrontEnd import graphicsPkg::*; #(
  parameter int framePeriod = 512
) (
  input wire Clk,
  input wire rstN,
  input wire soundClk,
  input wire [7:0] textStream,
  input wire signed [15:0] sound,
  output logic sampleStrobe,
  output logic byteStrobe,
  output streamByte_u streamByte,
  output logic [15:0] soundMagnitude,
  output logic frameTick
);

  localparam int countWidth = $clog2(framePeriod + 1);

  logic clkSync;
  logic clkSyncLast;
  logic [7:0] textReg;
  logic signed [15:0] soundReg;
  logic [countWidth-1:0] sampleCount;

  // Inputs sampled alongside the sound clock
  always_ff @(posedge Clk) begin
    textReg <= textStream;
    soundReg <= sound;
  end

  // ------------------------------
  // Edge detection
  // ------------------------------
  always_ff @(posedge Clk) begin
    if (!rstN) begin
      clkSync <= 1'b0;
      clkSyncLast <= 1'b0;
      sampleStrobe <= 1'b0;
      byteStrobe <= 1'b0;
    end else begin
      clkSync <= soundClk;
      clkSyncLast <= clkSync;
      sampleStrobe <= clkSync ^ clkSyncLast;
      // Stream bytes change on the falling edge
      byteStrobe <= clkSyncLast & ~clkSync;
    end
  end

  // Payload captured on the edge, presented with the strobes
  always_ff @(posedge Clk) begin
    if (clkSync ^ clkSyncLast) begin
      streamByte <= textReg;
      soundMagnitude <= soundReg[15] ? 16'(-soundReg) : 16'(soundReg);
    end
  end

  // ------------------------------
  // Frame tick
  // ------------------------------
  assign frameTick = sampleStrobe && (sampleCount == countWidth'(framePeriod - 1));

  always_ff @(posedge Clk) begin
    if (!rstN) begin
      sampleCount <= '0;
    end else if (frameTick) begin
      sampleCount <= '0;
    end else if (sampleStrobe) begin
      sampleCount <= sampleCount + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/headerPainter.sv
// Header painter: clears the screen, then paints the channel, artist and title labels
`default_nettype none

module headerPainter import graphicsPkg::*; (
  input wire Clk,
  input wire rstN,
  input wire [2:0] channel,
  input wire ack,
  output logic cyc,
  output logic stb,
  output logic [cellAddrWidth-1:0] adr,
  output logic [cellDataWidth-1:0] dat
);

  localparam logic [1:0] stateClear = 2'd0;
  localparam logic [1:0] stateLabels = 2'd1;
  localparam logic [1:0] stateIdle = 2'd2;

  logic [1:0] state;
  logic [4:0] row;
  logic [6:0] col;
  logic [2:0] chan;
  logic clearing;
  logic lastCol;
  logic lastRow;
  logic [7:0] labelGlyph;
  logic [11:0] labelColour;

  assign clearing = (state == stateClear);
  assign lastCol = clearing ? (col == 7'(screenCols - 1)) : (col == 7'd10);
  assign lastRow = clearing ? (row == 5'(screenRows - 1)) : (row == 5'(4 * slotCount - 1));

  // ------------------------------
  // Label text
  // ------------------------------
  always_comb begin
    labelGlyph = 8'h00;
    case (row[1:0])
      2'd1: begin
        case (col)
          7'd0: labelGlyph = "C";
          7'd1: labelGlyph = "h";
          7'd2: labelGlyph = "a";
          7'd3, 7'd4: labelGlyph = "n";
          7'd5: labelGlyph = "e";
          7'd6: labelGlyph = "l";
          7'd8: labelGlyph = 8'h31 + {5'd0, row[4:2]};
          7'd9: labelGlyph = ":";
          default: labelGlyph = 8'h00;
        endcase
      end
      2'd2: begin
        case (col)
          7'd1: labelGlyph = "A";
          7'd2: labelGlyph = "r";
          7'd3, 7'd6: labelGlyph = "t";
          7'd4: labelGlyph = "i";
          7'd5: labelGlyph = "s";
          7'd7: labelGlyph = ":";
          default: labelGlyph = 8'h00;
        endcase
      end
      2'd3: begin
        case (col)
          7'd1, 7'd3: labelGlyph = (col == 7'd1) ? "T" : "t";
          7'd2: labelGlyph = "i";
          7'd4: labelGlyph = "l";
          7'd5: labelGlyph = "e";
          7'd6: labelGlyph = ":";
          default: labelGlyph = 8'h00;
        endcase
      end
      default: labelGlyph = 8'h00;
    endcase
  end

  // Whole four-line block of the selected slot is highlighted
  assign labelColour = (row[4:2] == chan) ? colourSelected : colourIdle;

  assign stb = cyc;
  assign adr = cellAddr(row, col);
  assign dat = clearing ? '0 : {labelGlyph, labelColour};

  // ------------------------------
  // Sequencer
  // ------------------------------
  always_ff @(posedge Clk) begin
    if (!rstN) begin
      state <= stateClear;
      cyc <= 1'b0;
      row <= '0;
      col <= '0;
      chan <= '0;
    end else if (state == stateIdle) begin
      if (channel != chan) begin
        chan <= channel;
        state <= stateLabels;
      end
    end else if (!cyc) begin
      cyc <= 1'b1;
    end else if (ack) begin
      cyc <= 1'b0;
      if (!lastCol) begin
        col <= col + 1'b1;
      end else begin
        col <= '0;
        if (!lastRow) begin
          row <= row + 1'b1;
        end else begin
          row <= '0;
          state <= clearing ? stateLabels : stateIdle;
          if (clearing) chan <= channel;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/metadataWriter.sv
// Metadata writer: puts streamed artist and title text into a channel slot
`default_nettype none

module metadataWriter import graphicsPkg::*; (
  input wire Clk,
  input wire rstN,
  input wire [2:0] channel,
  input wire byteStrobe,
  input wire streamByte_u streamByte,
  input wire ack,
  output logic cyc,
  output logic stb,
  output logic [cellAddrWidth-1:0] adr,
  output logic [cellDataWidth-1:0] dat
);

  localparam logic [1:0] stateIdle = 2'd0;
  localparam logic [1:0] stateText = 2'd1;
  localparam logic [1:0] stateClear = 2'd2;
  localparam logic [6:0] textStartCol = 7'd9;
  localparam logic [6:0] textEndCol = 7'd77;

  logic [1:0] state;
  logic [2:0] slot;
  logic onTitle;
  logic [6:0] col;
  logic [7:0] glyph;
  logic [11:0] colour;
  logic [2:0] nextSlot;
  logic slotValid;

  // Message header byte is 1 to 6 with a clear high field
  assign nextSlot = streamByte.slotSelect.slot - 1'b1;
  assign slotValid = (streamByte.slotSelect.high == '0) &&
                     (streamByte.slotSelect.slot != 3'd0) &&
                     (streamByte.slotSelect.slot <= 3'(slotCount));

  assign stb = cyc;
  // Artist line is 4s+2, title line 4s+3
  assign adr = cellAddr({slot, 1'b1, onTitle}, col);
  assign dat = {glyph, colour};

  always_ff @(posedge Clk) begin
    if (!rstN) begin
      state <= stateIdle;
      cyc <= 1'b0;
      onTitle <= 1'b0;
      col <= textStartCol;
    end else begin
      case (state)
        stateIdle: begin
          if (byteStrobe && slotValid) begin
            onTitle <= 1'b0;
            col <= textStartCol;
            state <= stateText;
          end
        end

        // ------------------------------
        // One glyph per stream byte
        // ------------------------------
        stateText: begin
          if (cyc) begin
            if (ack) begin
              cyc <= 1'b0;
              col <= col + 1'b1;
            end
          end else if (byteStrobe) begin
            if (streamByte.glyph != 8'h00) begin
              cyc <= 1'b1;
            end else begin
              state <= stateClear;
            end
          end
        end

        // Blank the rest of the line
        stateClear: begin
          if (!cyc) begin
            cyc <= 1'b1;
          end else if (ack) begin
            cyc <= 1'b0;
            if (col != textEndCol) begin
              col <= col + 1'b1;
            end else if (onTitle) begin
              state <= stateIdle;
            end else begin
              onTitle <= 1'b1;
              col <= textStartCol;
              state <= stateText;
            end
          end
        end

        default: state <= stateIdle;
      endcase
    end
  end

  // Slot, colour and glyph only change while no write is pending
  always_ff @(posedge Clk) begin
    if (state == stateIdle && byteStrobe && slotValid) begin
      slot <= nextSlot;
      colour <= (nextSlot == channel) ? colourPlaying : colourIdle;
    end
    if (state == stateText && !cyc && byteStrobe) begin
      glyph <= streamByte.glyph;
    end
  end

endmodule

`default_nettype wire

//--- verilog/levelMeter.sv
// Level meter: frame peak detector and 20-row bar painter in the meter column
`default_nettype none

module levelMeter import graphicsPkg::*; (
  input wire Clk,
  input wire rstN,
  input wire sampleStrobe,
  input wire [15:0] soundMagnitude,
  input wire frameTick,
  input wire ack,
  output logic cyc,
  output logic stb,
  output logic [cellAddrWidth-1:0] adr,
  output logic [cellDataWidth-1:0] dat
);

  logic [15:0] peak;
  logic [15:0] nextPeak;
  logic [15:0] framePeak;
  logic pending;
  logic busy;
  logic [4:0] row;
  logic [meterRows-1:0] reached;
  logic [meterRows-1:0] lit;
  logic [11:0] bandColour;

  assign nextPeak = (sampleStrobe && soundMagnitude > peak) ? soundMagnitude : peak;

  always_comb begin
    for (int k = 0; k < meterRows; k++) begin
      reached[k] = (framePeak >= levelThresholds[k]);
    end
  end

  // Green, yellow and red bands from the bottom up
  always_comb begin
    if (row <= 5'd12) bandColour = 12'h0F0;
    else if (row <= 5'd17) bandColour = 12'hFF0;
    else bandColour = 12'hF00;
  end

  assign stb = cyc;
  assign adr = cellAddr(5'(meterBottomRow - row), 7'(meterColumn));
  assign dat = {glyphBlock, lit[row] ? bandColour : 12'h000};

  // Bar pattern frozen for the whole paint pass
  always_ff @(posedge Clk) begin
    if (frameTick) framePeak <= nextPeak;
    if (!busy && pending) lit <= reached;
  end

  always_ff @(posedge Clk) begin
    if (!rstN) begin
      peak <= '0;
      pending <= 1'b0;
      busy <= 1'b0;
      cyc <= 1'b0;
      row <= '0;
    end else begin
      // ------------------------------
      // Painter
      // ------------------------------
      if (!busy) begin
        if (pending) begin
          busy <= 1'b1;
          pending <= 1'b0;
          row <= '0;
        end
      end else if (!cyc) begin
        cyc <= 1'b1;
      end else if (ack) begin
        cyc <= 1'b0;
        if (row == 5'(meterRows - 1)) busy <= 1'b0;
        else row <= row + 1'b1;
      end

      // A new frame wins over the start of a paint pass
      if (frameTick) begin
        peak <= '0;
        pending <= 1'b1;
      end else begin
        peak <= nextPeak;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/cellArbiter.sv
// Cell bus arbiter: fixed priority of header, metadata and meter masters onto one slave
`default_nettype none

module cellArbiter import graphicsPkg::*; (
  input wire Clk,
  input wire rstN,
  input wire headerCyc,
  input wire headerStb,
  input wire [cellAddrWidth-1:0] headerAdr,
  input wire [cellDataWidth-1:0] headerDat,
  output logic headerAck,
  input wire metaCyc,
  input wire metaStb,
  input wire [cellAddrWidth-1:0] metaAdr,
  input wire [cellDataWidth-1:0] metaDat,
  output logic metaAck,
  input wire meterCyc,
  input wire meterStb,
  input wire [cellAddrWidth-1:0] meterAdr,
  input wire [cellDataWidth-1:0] meterDat,
  output logic meterAck,
  output logic busCyc,
  output logic busStb,
  output logic [cellAddrWidth-1:0] busAdr,
  output logic [cellDataWidth-1:0] busDat,
  input wire busAck
);

  // One-hot, bit 0 header, bit 1 metadata, bit 2 meter
  logic [2:0] grant;
  logic [2:0] active;
  logic [2:0] cycVec;

  assign cycVec = {meterCyc, metaCyc, headerCyc};

  // Hold the owner while its cycle lasts, otherwise pick by priority
  always_comb begin
    if ((grant & cycVec) != 3'b000) active = grant;
    else if (headerCyc) active = 3'b001;
    else if (metaCyc) active = 3'b010;
    else if (meterCyc) active = 3'b100;
    else active = 3'b000;
  end

  always_ff @(posedge Clk) begin
    if (!rstN) grant <= 3'b000;
    else grant <= active;
  end

  // ------------------------------
  // Bus multiplexer
  // ------------------------------
  always_comb begin
    busCyc = 1'b0;
    busStb = 1'b0;
    busAdr = '0;
    busDat = '0;
    case (active)
      3'b001: {busCyc, busStb, busAdr, busDat} = {headerCyc, headerStb, headerAdr, headerDat};
      3'b010: {busCyc, busStb, busAdr, busDat} = {metaCyc, metaStb, metaAdr, metaDat};
      3'b100: {busCyc, busStb, busAdr, busDat} = {meterCyc, meterStb, meterAdr, meterDat};
      default: ;
    endcase
  end

  assign headerAck = busAck & active[0];
  assign metaAck = busAck & active[1];
  assign meterAck = busAck & active[2];

endmodule

`default_nettype wire

//--- verilog/screenBuffer.sv
// Screen buffer: 80 x 30 cell memory with a Wishbone write port and a scanout read port
`default_nettype none

module screenBuffer import graphicsPkg::*; (
  input wire Clk,
  input wire busCyc,
  input wire busStb,
  input wire [cellAddrWidth-1:0] busAdr,
  input wire [cellDataWidth-1:0] busDat,
  output logic busAck,
  input wire [cellAddrWidth-1:0] readAddr,
  output logic [cellDataWidth-1:0] readCell
);

  logic [cellDataWidth-1:0] cells [screenCols * screenRows];
  logic writeEn;

  // One write and one ack per strobe, even if stb stays high during the ack
  assign writeEn = busCyc & busStb & ~busAck;

  always_ff @(posedge Clk) begin
    busAck <= writeEn;
    if (writeEn) cells[busAdr] <= busDat;
  end

  // Scanout port
  always_ff @(posedge Clk) begin
    readCell <= cells[readAddr];
  end

endmodule

`default_nettype wire

//--- verilog/graphicsTop.sv
// Graphics top: three cell painters sharing one Wishbone bus into the screen buffer
`default_nettype none

module graphicsTop import graphicsPkg::*; #(
  parameter int framePeriod = 512
) (
  input wire Clk,
  input wire rstN,
  input wire [2:0] channel,
  input wire soundClk,
  input wire [7:0] textStream,
  input wire signed [15:0] sound,
  input wire [cellAddrWidth-1:0] readAddr,
  output logic [cellDataWidth-1:0] readCell
);

  logic sampleStrobe;
  logic byteStrobe;
  streamByte_u streamByte;
  logic [15:0] soundMagnitude;
  logic frameTick;

  // Painter buses
  logic headerCyc, headerStb, headerAck;
  logic [cellAddrWidth-1:0] headerAdr;
  logic [cellDataWidth-1:0] headerDat;
  logic metaCyc, metaStb, metaAck;
  logic [cellAddrWidth-1:0] metaAdr;
  logic [cellDataWidth-1:0] metaDat;
  logic meterCyc, meterStb, meterAck;
  logic [cellAddrWidth-1:0] meterAdr;
  logic [cellDataWidth-1:0] meterDat;

  // Shared slave bus
  logic busCyc, busStb, busAck;
  logic [cellAddrWidth-1:0] busAdr;
  logic [cellDataWidth-1:0] busDat;

  soundFrontEnd #(.framePeriod(framePeriod)) soundFrontEnd_inst (
    .Clk(Clk), .rstN(rstN), .soundClk(soundClk), .textStream(textStream), .sound(sound),
    .sampleStrobe(sampleStrobe), .byteStrobe(byteStrobe), .streamByte(streamByte),
    .soundMagnitude(soundMagnitude), .frameTick(frameTick)
  );

  headerPainter headerPainter_inst (
    .Clk(Clk), .rstN(rstN), .channel(channel), .ack(headerAck),
    .cyc(headerCyc), .stb(headerStb), .adr(headerAdr), .dat(headerDat)
  );

  metadataWriter metadataWriter_inst (
    .Clk(Clk), .rstN(rstN), .channel(channel), .byteStrobe(byteStrobe),
    .streamByte(streamByte), .ack(metaAck),
    .cyc(metaCyc), .stb(metaStb), .adr(metaAdr), .dat(metaDat)
  );

  levelMeter levelMeter_inst (
    .Clk(Clk), .rstN(rstN), .sampleStrobe(sampleStrobe), .soundMagnitude(soundMagnitude),
    .frameTick(frameTick), .ack(meterAck),
    .cyc(meterCyc), .stb(meterStb), .adr(meterAdr), .dat(meterDat)
  );

  cellArbiter cellArbiter_inst (
    .Clk(Clk), .rstN(rstN),
    .headerCyc(headerCyc), .headerStb(headerStb), .headerAdr(headerAdr),
    .headerDat(headerDat), .headerAck(headerAck),
    .metaCyc(metaCyc), .metaStb(metaStb), .metaAdr(metaAdr),
    .metaDat(metaDat), .metaAck(metaAck),
    .meterCyc(meterCyc), .meterStb(meterStb), .meterAdr(meterAdr),
    .meterDat(meterDat), .meterAck(meterAck),
    .busCyc(busCyc), .busStb(busStb), .busAdr(busAdr), .busDat(busDat), .busAck(busAck)
  );

  screenBuffer screenBuffer_inst (
    .Clk(Clk), .busCyc(busCyc), .busStb(busStb), .busAdr(busAdr), .busDat(busDat),
    .busAck(busAck), .readAddr(readAddr), .readCell(readCell)
  );

endmodule

`default_nettype wire

//--- sim/clockGen.sv
// Testbench clock and reset: 10-unit clock period, reset held low for two cycles
`default_nettype none

module clockGen (
  output logic Clk,
  output logic rstN
);

  initial begin
    Clk = 1'b0;
    forever #5 Clk = ~Clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (2) @(posedge Clk);
    #1 rstN = 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/cellBus_properties.sv
// Cell bus properties: ack routing, one-cycle ack and master hold until ack
`default_nettype none

module cellBusProperties (
  input wire Clk,
  input wire rstN,
  input wire busAck,
  input wire [11:0] busAdr,
  input wire [19:0] busDat,
  input wire headerStb,
  input wire headerAck,
  input wire [11:0] headerAdr,
  input wire [19:0] headerDat,
  input wire metaStb,
  input wire metaAck,
  input wire [11:0] metaAdr,
  input wire [19:0] metaDat,
  input wire meterStb,
  input wire meterAck,
  input wire [11:0] meterAdr,
  input wire [19:0] meterDat
);

  // Each ack goes to exactly one master, the one whose request was written
  ackOwner: assert property (@(posedge Clk) disable iff (!rstN)
    busAck |-> ($onehot({headerAck, metaAck, meterAck}) &&
      $past({busAdr, busDat}) == (headerAck ? {headerAdr, headerDat} :
                                  metaAck ? {metaAdr, metaDat} : {meterAdr, meterDat})))
    else $error("busAck routed to a master whose request was not written");

  ackPulse: assert property (@(posedge Clk) disable iff (!rstN) busAck |=> !busAck)
    else $error("busAck high for more than one cycle");

  // ------------------------------
  // Masters hold their request until ack
  // ------------------------------
  headerHold: assert property (@(posedge Clk) disable iff (!rstN)
    (headerStb && !headerAck) |=> (headerStb && $stable(headerAdr) && $stable(headerDat)))
    else $error("header master changed its request before ack");

  metaHold: assert property (@(posedge Clk) disable iff (!rstN)
    (metaStb && !metaAck) |=> (metaStb && $stable(metaAdr) && $stable(metaDat)))
    else $error("metadata master changed its request before ack");

  meterHold: assert property (@(posedge Clk) disable iff (!rstN)
    (meterStb && !meterAck) |=> (meterStb && $stable(meterAdr) && $stable(meterDat)))
    else $error("meter master changed its request before ack");

endmodule

bind cellArbiter cellBusProperties cellBusProperties_inst (
  .Clk(Clk), .rstN(rstN), .busAck(busAck), .busAdr(busAdr), .busDat(busDat),
  .headerStb(headerStb), .headerAck(headerAck), .headerAdr(headerAdr), .headerDat(headerDat),
  .metaStb(metaStb), .metaAck(metaAck), .metaAdr(metaAdr), .metaDat(metaDat),
  .meterStb(meterStb), .meterAck(meterAck), .meterAdr(meterAdr), .meterDat(meterDat)
);

`default_nettype wire

//--- sim/graphicsTb.sv
// Graphics testbench: random painting activity checked against a screen model
`default_nettype none

module graphicsTb;

  localparam int framePeriod = 16;
  localparam int sweepCycles = 2500;
  localparam int quietLimit = 20000;
  localparam int messageCount = 4;
  localparam int meterTrials = 4;
  // Cycle budgets per phase
  // A message is at most 43 bytes of two soundClk edges each
  localparam int resetBudget = 6000 + quietLimit + sweepCycles;
  localparam int channelBudget = 3 * (quietLimit + sweepCycles);
  localparam int messageBudget = messageCount * 43 * 2 * 250 + quietLimit + sweepCycles;
  localparam int meterBudget = meterTrials * (32 * 250 + quietLimit + sweepCycles);
  localparam int invalidBudget = 3 * 2 * 250 + quietLimit + sweepCycles;
  localparam int overlapBudget = 43 * 2 * 600 + quietLimit + sweepCycles;
  localparam int totalBudget = resetBudget + channelBudget + messageBudget + meterBudget +
                               invalidBudget + overlapBudget;

  logic Clk;
  logic rstN;
  logic [2:0] channel;
  logic soundClk;
  logic [7:0] textStream;
  logic [15:0] sound;
  logic [11:0] readAddr;
  logic [19:0] readCell;

  integer seed = 32'hcde9_11ce;
  int halfPeriod = 250;
  int amp = 0;
  int modelChannel = 0;
  int edgeCount = 0;
  int framePeak = 0;
  logic [19:0] model [2400];
  int thresholds [20] = '{328, 413, 519, 654, 823, 1036, 1305, 1642, 2068, 2603,
                          3277, 4125, 5193, 6538, 8231, 10362, 13045, 16423, 20675, 26029};

  clockGen clockGen_inst (.Clk(Clk), .rstN(rstN));

  graphicsTop #(.framePeriod(framePeriod)) graphicsTop_inst (
    .Clk(Clk), .rstN(rstN), .channel(channel), .soundClk(soundClk),
    .textStream(textStream), .sound(sound), .readAddr(readAddr), .readCell(readCell)
  );

  task automatic stopRun(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkEqual(input logic [19:0] actual, input logic [19:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at time %0t: %s got %h expected %h", $time, what, actual,
               expected);
      stopRun("Screen contents differ from the model");
    end
  endtask

  function automatic int randRange(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return lo + (r % (hi - lo + 1));
  endfunction

  // ------------------------------
  // Screen model
  // ------------------------------
  function automatic logic [7:0] labelGlyph(input int row, input int col);
    string text;
    logic [7:0] c;
    case (row % 4)
      1: text = $sformatf("Channel %0d:", row / 4 + 1);
      2: text = " Artist:";
      3: text = " Title:";
      default: text = "";
    endcase
    if (col >= text.len()) return 8'h00;
    c = text[col];
    return (c == " ") ? 8'h00 : c;
  endfunction

  task automatic paintLabels(input int ch);
    for (int row = 0; row < 24; row++) begin
      for (int col = 0; col <= 10; col++) begin
        model[row * 80 + col] = {labelGlyph(row, col), (row / 4 == ch) ? 12'h0E0 : 12'h00F};
      end
    end
  endtask

  task automatic paintMeter(input int level);
    logic [11:0] band;
    for (int k = 0; k < 20; k++) begin
      band = (k <= 12) ? 12'h0F0 : ((k <= 17) ? 12'hFF0 : 12'hF00);
      model[(24 - k) * 80 + 78] = {8'hDB, (level >= thresholds[k]) ? band : 12'h000};
    end
  endtask

  // Every soundClk edge is one sample
  // Every framePeriod samples give one bar update
  task automatic noteSample(input int mag);
    if (mag > framePeak) framePeak = mag;
    edgeCount++;
    if (edgeCount % framePeriod == 0) begin
      paintMeter(framePeak);
      framePeak = 0;
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic toggleSoundClk();
    @(posedge Clk);
    #1;
    soundClk = ~soundClk;
    sound = soundClk ? 16'(amp) : 16'(-amp);
    noteSample(amp);
    repeat (halfPeriod - 1) @(posedge Clk);
  endtask

  // Byte is taken on the falling edge
  task automatic sendByte(input logic [7:0] value);
    @(posedge Clk);
    #1 textStream = value;
    toggleSoundClk();
    toggleSoundClk();
  endtask

  task automatic setChannel(input int ch);
    @(posedge Clk);
    #1 channel = 3'(ch);
    if (ch != modelChannel) paintLabels(ch);
    modelChannel = ch;
  endtask

  task automatic writeLine(input int row, input int len, input logic [11:0] colour,
                           input int changeAt, input int newChannel);
    logic [7:0] b;
    int col;
    col = 9;
    for (int i = 0; i < len; i++) begin
      b = 8'(randRange(8'h20, 8'h7E));
      sendByte(b);
      model[row * 80 + col] = {b, colour};
      col++;
      if (i + 1 == changeAt) setChannel(newChannel);
    end
    sendByte(8'h00);
    while (col <= 77) begin
      model[row * 80 + col] = {8'h00, colour};
      col++;
    end
  endtask

  task automatic runMessage(input int slot, input int artistLen, input int titleLen,
                            input int changeAt, input int newChannel);
    logic [11:0] colour;
    colour = (slot == modelChannel) ? 12'hF00 : 12'h00F;
    sendByte(8'(slot + 1));
    writeLine(4 * slot + 2, artistLen, colour, changeAt, newChannel);
    writeLine(4 * slot + 3, titleLen, colour, -1, 0);
  endtask

  task automatic waitQuiet();
    int idleRun;
    int cycles;
    idleRun = 0;
    cycles = 0;
    while (idleRun < 32) begin
      @(posedge Clk);
      #1;
      if (graphicsTop_inst.headerCyc || graphicsTop_inst.metaCyc ||
          graphicsTop_inst.meterCyc) idleRun = 0;
      else idleRun++;
      cycles++;
      if (cycles > quietLimit) stopRun("Painters did not go idle in time");
    end
  endtask

  task automatic sweepScreen(input string phase);
    @(posedge Clk);
    #1 readAddr = 12'd0;
    for (int a = 0; a < 2400; a++) begin
      @(posedge Clk);
      #1;
      checkEqual(readCell, model[a], $sformatf("%s cell %0d", phase, a));
      readAddr = 12'(a + 1);
    end
  endtask

  // Watchdog
  initial begin
    repeat (2 * totalBudget) @(posedge Clk);
    stopRun("Timeout: the test did not finish within its cycle budget");
  end

  initial begin
    int newCh;
    channel = 3'd0;
    soundClk = 1'b0;
    textStream = 8'h00;
    sound = 16'h0000;
    readAddr = 12'd0;
    for (int a = 0; a < 2400; a++) model[a] = 20'h00000;
    paintLabels(0);
    wait (rstN);
    waitQuiet();
    sweepScreen("reset");

    for (int i = 0; i < 3; i++) begin
      setChannel((modelChannel + randRange(1, 5)) % 6);
      waitQuiet();
      sweepScreen("channel");
    end

    for (int i = 0; i < messageCount; i++) begin
      runMessage(randRange(0, 5), randRange(0, 20), randRange(0, 20), -1, 0);
      waitQuiet();
      sweepScreen("metadata");
    end

    for (int i = 0; i < meterTrials; i++) begin
      amp = randRange(0, 30000);
      repeat (2 * framePeriod) toggleSoundClk();
      waitQuiet();
      sweepScreen("meter");
    end

    sendByte(8'h00);
    sendByte(8'h07);
    sendByte({5'(randRange(1, 31)), 3'(randRange(1, 6))});
    waitQuiet();
    sweepScreen("invalid");

    // Repaint starts once the message is past the label columns
    halfPeriod = 600;
    amp = randRange(0, 30000);
    newCh = (modelChannel + randRange(1, 5)) % 6;
    runMessage(randRange(0, 5), randRange(3, 20), randRange(0, 20), 3, newCh);
    waitQuiet();
    sweepScreen("overlap");

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
verilog/graphicsPkg.sv
verilog/soundFrontEnd.sv
verilog/headerPainter.sv
verilog/metadataWriter.sv
verilog/levelMeter.sv
verilog/cellArbiter.sv
verilog/screenBuffer.sv
verilog/graphicsTop.sv
sim/clockGen.sv
sim/cellBus_properties.sv
sim/graphicsTb.sv

//--- run.sh
#!/bin/sh
# Build and run the graphics testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module graphicsTb \
  -Mdir obj_dir -f project.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed"
  exit $status
fi

./obj_dir/VgraphicsTb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed"
  exit $status
fi
exit 0
